// File: verilog.f
+incdir+test
hw/axi_pkg.sv
hw/mem_map_pkg.sv
hw/fifo_same_clock.sv
hw/axibram_write.sv
hw/wr_dev_sel.sv
hw/bram_bank.sv
hw/axi_bram_sub.sv
test/tb_axi_bram_sub.sv

// File: run_sim.sh
#!/bin/sh
# build and run the AXI write subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
   --top-module tb_axi_bram_sub \
   -f verilog.f \
   -o sim_axi_bram_sub

./obj_dir/sim_axi_bram_sub > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
   exit 0
fi
exit 1

// File: test/tb_axi_bram_tasks.svh
// random source, reference model, AXI driver and compare tasks for the testbench
`ifndef TB_AXI_BRAM_TASKS_SVH
`define TB_AXI_BRAM_TASKS_SVH

function automatic logic [31:0] xorshift32();
   rng = rng ^ (rng << 13);
   rng = rng ^ (rng >> 17);
   rng = rng ^ (rng << 5);
   return rng;
endfunction

// applies one beat to the model memory and returns the word expected there
function automatic logic [31:0] ref_beat(input int start, input axi_burst_e burst,
                                         input int len, input int idx,
                                         input logic [31:0] data, input logic [3:0] strb);
   int a;
   case (burst)
      INCR:    a = start + idx;
      WRAP:    a = (start & ~len) | ((start + idx) & len);   // window of len+1 words
      default: a = start;
   endcase
   if (burst == RESERVED) return model_mem[a];           // nothing written
   for (int b = 0; b < 4; b++) begin
      if (strb[b]) model_mem[a][8*b +: 8] = data[8*b +: 8];
   end
   written[a] = 1'b1;
   return model_mem[a];
endfunction

function automatic axi_resp_e ref_resp(input axi_burst_e burst);
   return (burst == RESERVED) ? SLVERR : OKAY;
endfunction

task automatic check_word(input string name, input logic [AXI_DATA_W-1:0] got,
                          input logic [AXI_DATA_W-1:0] exp);
   if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %08h expected %08h", $time, name, got, exp);
      err_cnt++;
   end
endtask

task automatic check_resp(input string name, input axi_resp_e got, input axi_resp_e exp);
   if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
      err_cnt++;
   end
endtask

task automatic check_id(input string name, input logic [AXI_ID_W-1:0] got,
                        input logic [AXI_ID_W-1:0] exp);
   if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %03h expected %03h", $time, name, got, exp);
      err_cnt++;
   end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
      err_cnt++;
   end
endtask

// waits on awready when which is 0 and on wready otherwise
// returns just after the handshake edge
task automatic wait_handshake(input int which, input string what);
   int n;
   n = 0;
   while ((which == 0 ? awready : wready) !== 1'b1 && n < 1000) begin
      @(negedge aclk);
      n++;
   end
   if (n >= 1000) begin
      $display("timeout: %s was never accepted by the slave", what);
      err_cnt++;
   end
   @(posedge aclk);
   #1;
endtask

// sends one burst from beat_data / beat_strb and updates the model
task automatic send_burst(input int addr, input int id, input int len,
                          input axi_burst_e burst);
   exp_id.push_back(AXI_ID_W'(id));
   exp_resp.push_back(ref_resp(burst));
   awaddr  = 32'(addr) << 2;
   awid    = AXI_ID_W'(id);
   awlen   = AXI_LEN_W'(len);
   awburst = burst;
   awvalid = 1'b1;
   @(negedge aclk);
   wait_handshake(0, "write address");
   awvalid = 1'b0;
   for (int i = 0; i <= len; i++) begin
      wdata  = beat_data[i];
      wstrb  = beat_strb[i];
      wid    = AXI_ID_W'(id);
      wlast  = (i == len);
      wvalid = 1'b1;
      @(negedge aclk);
      wait_handshake(1, "write data beat");
      wvalid = 1'b0;
      void'(ref_beat(addr, burst, len, i, beat_data[i], beat_strb[i]));
   end
endtask

`endif

// File: test/tb_axi_bram_sub.sv
// testbench for the AXI3 write subsystem
// random bursts checked against a model memory through the local read port
`default_nettype none

module tb_axi_bram_sub;
   import axi_pkg::*;

   localparam int AB = 10;                  // word address bits

   logic                  aclk;
   logic                  rst;
   logic [AXI_ADDR_W-1:0] awaddr;
   logic                  awvalid;
   logic                  awready;
   logic [AXI_ID_W-1:0]   awid;
   logic [AXI_LEN_W-1:0]  awlen;
   logic [1:0]            awsize;
   axi_burst_e            awburst;
   logic [AXI_DATA_W-1:0] wdata;
   logic                  wvalid;
   logic                  wready;
   logic [AXI_ID_W-1:0]   wid;
   logic                  wlast;
   logic [AXI_STRB_W-1:0] wstrb;
   logic                  bvalid;
   logic                  bready;
   logic [AXI_ID_W-1:0]   bid;
   axi_resp_e             bresp;
   logic                  rd_en;
   logic [AB-1:0]         rd_addr;
   logic [AXI_DATA_W-1:0] rd_data;
   logic                  rd_valid;

   logic [31:0]           rng;
   logic [31:0]           model_mem [2**AB];
   logic                  written [2**AB];   // word holds a known value
   logic [31:0]           beat_data [16];
   logic [3:0]            beat_strb [16];
   logic [AXI_ID_W-1:0]   exp_id [$];
   axi_resp_e             exp_resp [$];
   int                    err_cnt;
   int                    test_cnt;
   int                    test_fail;
   logic                  writes_done;

   `include "tb_axi_bram_tasks.svh"

   axi_bram_sub #(.ADDRESS_BITS(AB)) i_dut (.*);

   always #5 aclk = !aclk;

   // bready and bvalid are settled at the falling edge
   always @(negedge aclk) begin
      if (!rst && bvalid && bready) begin
         if (exp_id.size() == 0) begin
            $display("unexpected response with id %03h at t=%0t", bid, $time);
            err_cnt++;
         end else begin
            check_id("bid", bid, exp_id.pop_front());
            check_resp("bresp", bresp, exp_resp.pop_front());
         end
      end
   end

   task automatic fill_beats(input int len, input bit full);
      for (int i = 0; i <= len; i++) begin
         beat_data[i] = xorshift32();
         beat_strb[i] = full ? 4'hf : 4'(xorshift32());
      end
   endtask

   task automatic drain_responses();
      int n;
      n = 0;
      while (exp_id.size() != 0 && n < 5000) begin
         @(posedge aclk);
         n++;
      end
      if (n >= 5000) begin
         $display("timeout: %0d responses never arrived", exp_id.size());
         err_cnt++;
      end
      #1;
   endtask

   task automatic read_word(input int addr, output logic [31:0] data);
      int n;
      n = 0;
      rd_en   = 1'b1;
      rd_addr = AB'(addr);
      @(posedge aclk);
      #1;
      rd_en = 1'b0;
      @(negedge aclk);
      while (rd_valid !== 1'b1 && n < 100) begin
         @(negedge aclk);
         n++;
      end
      if (n >= 100) begin
         $display("timeout: read of word %0d never returned", addr);
         err_cnt++;
      end
      data = rd_data;
      @(posedge aclk);
      #1;
   endtask

   // reads back every word the model knows
   task automatic verify_all();
      logic [31:0] got;
      for (int a = 0; a < 2**AB; a++) begin
         if (written[a]) begin
            read_word(a, got);
            check_word($sformatf("rd_data[%0d]", a), got, model_mem[a]);
         end
      end
   endtask

   task automatic end_test(input string name, input int errs_before);
      test_cnt++;
      if (err_cnt == errs_before) begin
         $display("test %0d %s: ok", test_cnt, name);
      end else begin
         $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
         test_fail++;
      end
   endtask

   initial begin
      int e;
      int addr;
      int len;
      int base;
      int n;
      aclk        = 1'b0;
      rst         = 1'b1;
      awaddr      = '0;
      awvalid     = 1'b0;
      awid        = '0;
      awlen       = '0;
      awsize      = 2'd2;
      awburst     = INCR;
      wdata       = '0;
      wvalid      = 1'b0;
      wid         = '0;
      wlast       = 1'b0;
      wstrb       = '0;
      bready      = 1'b1;
      rd_en       = 1'b0;
      rd_addr     = '0;
      rng         = 32'd44647;
      err_cnt     = 0;
      test_cnt    = 0;
      test_fail   = 0;
      writes_done = 1'b0;
      for (int a = 0; a < 2**AB; a++) written[a] = 1'b0;
      repeat (5) @(posedge aclk);
      #1;
      rst = 1'b0;

      e = err_cnt;
      @(negedge aclk);
      check_flag("awready", awready, 1'b1);       // queues empty after reset
      check_flag("wready", wready, 1'b1);
      check_flag("bvalid", bvalid, 1'b0);
      check_flag("rd_valid", rd_valid, 1'b0);
      @(posedge aclk);
      #1;
      end_test("reset state", e);

      e = err_cnt;
      for (int k = 0; k < 6; k++) begin
         addr = (k % 2) * 512 + int'(xorshift32() % 496);   // banks take turns
         len  = int'(xorshift32() % 16);
         fill_beats(len, 1'b1);
         send_burst(addr, k, len, INCR);
      end
      drain_responses();
      verify_all();
      end_test("incr bursts", e);

      e = err_cnt;
      addr = 300;                                   // bank 0
      fill_beats(7, 1'b1);
      send_burst(addr, 16, 7, INCR);
      fill_beats(7, 1'b0);
      send_burst(addr, 17, 7, INCR);
      drain_responses();
      verify_all();
      end_test("partial strobes", e);

      e = err_cnt;
      for (int k = 0; k < 4; k++) begin
         len  = (2 << k) - 1;                       // 2, 4, 8, 16 beats
         base = int'(xorshift32() % 1024) & ~len;
         fill_beats(len, 1'b1);
         send_burst(base + (len + 1) / 2, 32 + k, len, WRAP);
      end
      drain_responses();
      verify_all();
      end_test("wrap bursts", e);

      e = err_cnt;
      fill_beats(5, 1'b1);
      send_burst(700, 48, 5, FIXED);
      fill_beats(3, 1'b1);
      send_burst(100, 49, 3, INCR);
      fill_beats(3, 1'b1);
      send_burst(100, 50, 3, RESERVED);
      drain_responses();
      verify_all();
      end_test("fixed and reserved", e);

      e = err_cnt;
      bready = 1'b0;                                // responses pile up
      for (int k = 0; k < 6; k++) begin
         fill_beats(0, 1'b1);
         send_burst(600 + k, 64 + k, 0, INCR);
      end
      repeat (20) @(posedge aclk);
      #1;
      bready = 1'b1;
      drain_responses();
      verify_all();
      end_test("held bready", e);

      e = err_cnt;
      fork
         begin
            for (int k = 0; k < 4; k++) begin
               fill_beats(15, 1'b1);
               send_burst(520 + 16 * k, 80 + k, 15, INCR);
            end
            drain_responses();
            writes_done = 1'b1;
         end
         begin
            n = 0;
            while (!writes_done && n < 20000) begin
               rd_en   = (n % 3) == 0;              // one read in three cycles
               rd_addr = AB'(512 + (n % 512));
               @(posedge aclk);
               #1;
               n++;
            end
            rd_en = 1'b0;
            if (n >= 20000) begin
               $display("timeout: writes did not finish under read traffic");
               err_cnt++;
            end
         end
      join
      verify_all();
      end_test("reads during writes", e);

      $display("tests %0d, failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
      if (err_cnt == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: hw/axi_bram_sub.sv
// AXI3 write subsystem: write slave, bank selector and two memory banks,
// plus a local read port decoded by the top word-address bit
`default_nettype none

module axi_bram_sub #(
   parameter int ADDRESS_BITS = 10           // word address over both banks
) (
   input  wire                              aclk,
   input  wire                              rst,
   input  wire  [axi_pkg::AXI_ADDR_W-1:0]   awaddr,
   input  wire                              awvalid,
   output logic                             awready,
   input  wire  [axi_pkg::AXI_ID_W-1:0]     awid,
   input  wire  [axi_pkg::AXI_LEN_W-1:0]    awlen,
   input  wire  [1:0]                       awsize,
   input  wire  axi_pkg::axi_burst_e        awburst,
   input  wire  [axi_pkg::AXI_DATA_W-1:0]   wdata,
   input  wire                              wvalid,
   output logic                             wready,
   input  wire  [axi_pkg::AXI_ID_W-1:0]     wid,
   input  wire                              wlast,
   input  wire  [axi_pkg::AXI_STRB_W-1:0]   wstrb,
   output logic                             bvalid,
   input  wire                              bready,
   output logic [axi_pkg::AXI_ID_W-1:0]     bid,
   output axi_pkg::axi_resp_e               bresp,
   input  wire                              rd_en,
   input  wire  [ADDRESS_BITS-1:0]          rd_addr,
   output logic [axi_pkg::AXI_DATA_W-1:0]   rd_data,
   output logic                             rd_valid
);
   import axi_pkg::*;
   import mem_map_pkg::*;

   localparam int OW = ADDRESS_BITS - 1;    // offset bits inside a bank

   logic [ADDRESS_BITS-1:0] pre_awaddr;
   logic                    start_burst;
   logic                    dev_ready;
   logic [ADDRESS_BITS-1:0] bram_waddr;
   logic                    bram_wen;
   logic [AXI_STRB_W-1:0]   bram_wstrb;
   logic [AXI_DATA_W-1:0]   bram_wdata;
   logic [BANK_COUNT-1:0]   bank_ready;
   logic [BANK_COUNT-1:0]   wen_b;
   logic [BANK_COUNT-1:0]   rd_en_b;
   logic [BANK_COUNT-1:0]   rd_valid_b;
   logic [AXI_DATA_W-1:0]   rd_data_b [BANK_COUNT];
   logic [OW-1:0]           wr_ofs;
   logic [OW-1:0]           rd_ofs;
   bank_idx_t               rd_bank;
   bank_idx_t               rd_bank_r;         // steers the returning data

   assign wr_ofs  = OW'(offset_of(32'(bram_waddr), ADDRESS_BITS));
   assign rd_ofs  = OW'(offset_of(32'(rd_addr), ADDRESS_BITS));
   assign rd_bank = bank_of(32'(rd_addr), ADDRESS_BITS);
   assign rd_en_b = rd_en ? (BANK_COUNT'(1) << rd_bank) : '0;

   always_ff @(posedge aclk or posedge rst) begin
      if (rst) rd_bank_r <= '0;
      else if (rd_en) rd_bank_r <= rd_bank;
   end

   assign rd_data  = rd_data_b[rd_bank_r];
   assign rd_valid = |rd_valid_b;

   axibram_write #(.ADDRESS_BITS(ADDRESS_BITS)) i_write (
      .aclk, .rst,
      .awaddr, .awvalid, .awready, .awid, .awlen, .awsize, .awburst,
      .wdata, .wvalid, .wready, .wid, .wlast, .wstrb,
      .bvalid, .bready, .bid, .bresp,
      .pre_awaddr, .start_burst, .dev_ready,
      .bram_waddr, .bram_wen, .bram_wstrb, .bram_wdata
   );

   wr_dev_sel #(.ADDRESS_BITS(ADDRESS_BITS)) i_sel (
      .aclk, .rst,
      .pre_awaddr, .start_burst, .bram_wen,
      .bank_ready, .dev_ready, .wen_b
   );

   for (genvar i = 0; i < BANK_COUNT; i++) begin : bank_g
      bram_bank #(.ADDRESS_BITS(ADDRESS_BITS)) i_bank (
         .aclk       (aclk),
         .rst        (rst),
         .wen        (wen_b[i]),
         .waddr      (wr_ofs),
         .wstrb      (bram_wstrb),
         .wdata      (bram_wdata),
         .rd_en      (rd_en_b[i]),
         .rd_addr    (rd_ofs),
         .bank_ready (bank_ready[i]),
         .rd_data    (rd_data_b[i]),
         .rd_valid   (rd_valid_b[i])
      );
   end

endmodule

`default_nettype wire

// File: hw/bram_bank.sv
// single-port memory bank with byte-lane writes
// local reads take the port first and hold off the writer that cycle
`default_nettype none

module bram_bank #(
   parameter int ADDRESS_BITS = 10           // full word address, bank has half
) (
   input  wire                              aclk,
   input  wire                              rst,
   input  wire                              wen,
   input  wire  [ADDRESS_BITS-2:0]          waddr,
   input  wire  [axi_pkg::AXI_STRB_W-1:0]   wstrb,
   input  wire  [axi_pkg::AXI_DATA_W-1:0]   wdata,
   input  wire                              rd_en,
   input  wire  [ADDRESS_BITS-2:0]          rd_addr,
   output logic                             bank_ready,
   output logic [axi_pkg::AXI_DATA_W-1:0]   rd_data,
   output logic                             rd_valid
);
   import axi_pkg::*;

   localparam int WORDS = 2 ** (ADDRESS_BITS - 1);

   logic [AXI_DATA_W-1:0] mem [WORDS];

   assign bank_ready = !rd_en;              // port busy with a read

   always_ff @(posedge aclk) begin
      if (rd_en) begin
         rd_data <= mem[rd_addr];           // one cycle latency
      end else if (wen) begin
         for (int b = 0; b < AXI_STRB_W; b++) begin
            if (wstrb[b]) mem[waddr][8*b +: 8] <= wdata[8*b +: 8];
         end
      end
   end

   always_ff @(posedge aclk or posedge rst) begin
      if (rst) rd_valid <= 1'b0;
      else     rd_valid <= rd_en;
   end

endmodule

`default_nettype wire

// File: hw/wr_dev_sel.sv
// write device selector: latches the target bank at burst start,
// returns its ready and steers the write enable to it
`default_nettype none

module wr_dev_sel #(
   parameter int ADDRESS_BITS = 10
) (
   input  wire                                 aclk,
   input  wire                                 rst,
   input  wire  [ADDRESS_BITS-1:0]             pre_awaddr,
   input  wire                                 start_burst,
   input  wire                                 bram_wen,
   input  wire  [mem_map_pkg::BANK_COUNT-1:0]  bank_ready,
   output logic                                dev_ready,
   output logic [mem_map_pkg::BANK_COUNT-1:0]  wen_b
);
   import mem_map_pkg::*;

   bank_idx_t pre_bank;    // bank of the queued burst
   bank_idx_t sel_r;       // bank of the running burst
   bank_idx_t wr_bank;

   assign pre_bank = bank_of(32'(pre_awaddr), ADDRESS_BITS);

   always_ff @(posedge aclk or posedge rst) begin
      if (rst) sel_r <= '0;
      else if (start_burst) sel_r <= pre_bank;
   end

   assign wr_bank = start_burst ? pre_bank : sel_r;   // start beat bypasses latch

   // running and queued bank both free, so a start never depends on itself
   assign dev_ready = bank_ready[sel_r] && bank_ready[pre_bank];
   assign wen_b     = bram_wen ? (BANK_COUNT'(1) << wr_bank) : '0;

   a_wen_ready: assert property (@(posedge aclk) disable iff (rst)
      (wen_b & ~bank_ready) == '0)
      else $error("bank written while its read port is active");

endmodule

`default_nettype wire

// File: hw/axibram_write.sv
// AXI3 write slave: queues address, data and response, walks burst addresses
// and writes one beat per cycle while the selected device is ready
`default_nettype none

module axibram_write #(
   parameter int ADDRESS_BITS = 10           // word address bits
) (
   input  wire                              aclk,
   input  wire                              rst,
   input  wire  [axi_pkg::AXI_ADDR_W-1:0]   awaddr,
   input  wire                              awvalid,
   output logic                             awready,
   input  wire  [axi_pkg::AXI_ID_W-1:0]     awid,
   input  wire  [axi_pkg::AXI_LEN_W-1:0]    awlen,
   input  wire  [1:0]                       awsize,
   input  wire  axi_pkg::axi_burst_e        awburst,
   input  wire  [axi_pkg::AXI_DATA_W-1:0]   wdata,
   input  wire                              wvalid,
   output logic                             wready,
   input  wire  [axi_pkg::AXI_ID_W-1:0]     wid,
   input  wire                              wlast,
   input  wire  [axi_pkg::AXI_STRB_W-1:0]   wstrb,
   output logic                             bvalid,
   input  wire                              bready,
   output logic [axi_pkg::AXI_ID_W-1:0]     bid,
   output axi_pkg::axi_resp_e               bresp,
   output logic [ADDRESS_BITS-1:0]          pre_awaddr,
   output logic                             start_burst,
   input  wire                              dev_ready,
   output logic [ADDRESS_BITS-1:0]          bram_waddr,
   output logic                             bram_wen,
   output logic [axi_pkg::AXI_STRB_W-1:0]   bram_wstrb,
   output logic [axi_pkg::AXI_DATA_W-1:0]   bram_wdata
);
   import axi_pkg::*;

   localparam int AQ_W = AXI_ID_W + 2 + AXI_LEN_W + ADDRESS_BITS;
   localparam int WQ_W = AXI_ID_W + 1 + AXI_STRB_W + AXI_DATA_W;
   localparam int BQ_W = AXI_ID_W + 2;

   logic [AQ_W-1:0]         aw_head;
   logic [WQ_W-1:0]         w_head;
   logic [BQ_W-1:0]         b_head;
   logic                    aw_nempty;
   logic                    aw_half;
   logic                    w_nempty;
   logic                    w_half;
   logic                    b_half;

   logic [AXI_ID_W-1:0]     aw_id;     // address queue head fields
   axi_burst_e              aw_burst;
   logic [AXI_LEN_W-1:0]    aw_len;
   logic [ADDRESS_BITS-1:0] aw_addr;

   logic                    in_prog;   // beats remain after the start beat
   logic [AXI_LEN_W-1:0]    left;      // remaining beats minus one
   logic [ADDRESS_BITS-1:0] addr_r;
   axi_burst_e              burst_r;
   logic [AXI_LEN_W-1:0]    len_r;
   logic [AXI_ID_W-1:0]     id_r;
   logic                    dev_ready_r;

   logic                    go;
   logic                    mid_beat;
   logic                    beat;
   logic                    last_beat;
   axi_burst_e              cur_burst;
   logic [AXI_LEN_W-1:0]    cur_len;
   logic [AXI_ID_W-1:0]     cur_id;
   logic [ADDRESS_BITS-1:0] wrap_mask;
   logic [ADDRESS_BITS-1:0] next_addr;
   axi_resp_e               resp_in;

   assign aw_id    = aw_head[AQ_W-1 -: AXI_ID_W];
   assign aw_burst = axi_burst_e'(aw_head[AXI_LEN_W+ADDRESS_BITS +: 2]);
   assign aw_len   = aw_head[ADDRESS_BITS +: AXI_LEN_W];
   assign aw_addr  = aw_head[ADDRESS_BITS-1:0];

   // a beat needs both last cycle's ready and this cycle's ready
   assign go          = dev_ready_r && dev_ready;
   assign mid_beat    = in_prog && w_nempty && go;
   assign start_burst = !in_prog && aw_nempty && w_nempty && go && !b_half;
   assign beat        = start_burst || mid_beat;
   assign last_beat   = start_burst ? (aw_len == '0) : (mid_beat && left == '0);

   // start beat takes its burst fields straight from the queue head
   assign cur_burst  = start_burst ? aw_burst : burst_r;
   assign cur_len    = start_burst ? aw_len : len_r;
   assign cur_id     = start_burst ? aw_id : id_r;
   assign bram_waddr = start_burst ? aw_addr : addr_r;

   assign wrap_mask = ADDRESS_BITS'(cur_len);   // len+1 is the window size

   always_comb begin
      case (cur_burst)
         INCR:    next_addr = bram_waddr + ADDRESS_BITS'(1);
         WRAP:    next_addr = (bram_waddr & ~wrap_mask) |
                              ((bram_waddr + ADDRESS_BITS'(1)) & wrap_mask);
         default: next_addr = bram_waddr;       // fixed, reserved
      endcase
   end

   always_ff @(posedge aclk or posedge rst) begin
      if (rst) begin
         in_prog     <= 1'b0;
         left        <= '0;
         dev_ready_r <= 1'b0;
      end else begin
         dev_ready_r <= dev_ready;
         if (start_burst) begin
            in_prog <= aw_len != '0;           // single beat ends here
            left    <= aw_len - AXI_LEN_W'(1);
         end else if (mid_beat) begin
            in_prog <= left != '0;
            left    <= left - AXI_LEN_W'(1);
         end
      end
   end

   always_ff @(posedge aclk) begin
      if (start_burst) begin
         burst_r <= aw_burst;
         len_r   <= aw_len;
         id_r    <= aw_id;
      end
      if (beat) addr_r <= next_addr;
   end

   assign awready    = !aw_half;
   assign wready     = !w_half;
   assign pre_awaddr = aw_addr;
   assign bram_wen   = beat && cur_burst != RESERVED;   // reserved beats dropped
   assign bram_wstrb = w_head[AXI_DATA_W +: AXI_STRB_W];
   assign bram_wdata = w_head[AXI_DATA_W-1:0];
   assign resp_in    = (cur_burst == RESERVED) ? SLVERR : OKAY;
   assign bid        = b_head[BQ_W-1 -: AXI_ID_W];
   assign bresp      = axi_resp_e'(b_head[1:0]);

   fifo_same_clock #(.DATA_WIDTH(AQ_W), .DATA_DEPTH(8)) waddr_i (
      .aclk      (aclk),
      .rst       (rst),
      .we        (awvalid && awready),
      .re        (start_burst),
      .data_in   ({awid, awburst, awlen, awaddr[ADDRESS_BITS+1:2]}),
      .data_out  (aw_head),
      .nempty    (aw_nempty),
      .half_full (aw_half)
   );

   // wid and wlast ride along unchecked
   fifo_same_clock #(.DATA_WIDTH(WQ_W), .DATA_DEPTH(8)) wdata_i (
      .aclk      (aclk),
      .rst       (rst),
      .we        (wvalid && wready),
      .re        (beat),
      .data_in   ({wid, wlast, wstrb, wdata}),
      .data_out  (w_head),
      .nempty    (w_nempty),
      .half_full (w_half)
   );

   fifo_same_clock #(.DATA_WIDTH(BQ_W), .DATA_DEPTH(8)) wresp_i (
      .aclk      (aclk),
      .rst       (rst),
      .we        (last_beat),
      .re        (bvalid && bready),
      .data_in   ({cur_id, resp_in}),
      .data_out  (b_head),
      .nempty    (bvalid),
      .half_full (b_half)          // holds off new bursts
   );

   a_awsize_word: assert property (@(posedge aclk) disable iff (rst)
      awvalid |-> awsize == 2'd2)
      else $error("awsize other than 4 bytes");

endmodule

`default_nettype wire

// File: hw/fifo_same_clock.sv
// single-clock FIFO on a register array
// head entry shows on data_out, flags come from the fill count
`default_nettype none

module fifo_same_clock #(
   parameter int DATA_WIDTH = 16,
   parameter int DATA_DEPTH = 8     // entries, power of two
) (
   input  wire                   aclk,
   input  wire                   rst,
   input  wire                   we,
   input  wire                   re,
   input  wire  [DATA_WIDTH-1:0] data_in,
   output logic [DATA_WIDTH-1:0] data_out,
   output logic                  nempty,
   output logic                  half_full
);
   localparam int PW = $clog2(DATA_DEPTH);
   localparam int CW = $clog2(DATA_DEPTH + 1);

   logic [DATA_WIDTH-1:0] ram [DATA_DEPTH];
   logic [PW-1:0]         wptr;
   logic [PW-1:0]         rptr;
   logic [CW-1:0]         fill;       // entries held

   always_ff @(posedge aclk) begin
      if (we) ram[wptr] <= data_in;
   end

   always_ff @(posedge aclk or posedge rst) begin
      if (rst) begin
         wptr <= '0;
         rptr <= '0;
         fill <= '0;
      end else begin
         if (we) wptr <= wptr + PW'(1);   // wraps at depth
         if (re) rptr <= rptr + PW'(1);
         case ({we, re})
            2'b10:   fill <= fill + CW'(1);
            2'b01:   fill <= fill - CW'(1);
            default: ;                    // both or neither, count holds
         endcase
      end
   end

   assign data_out  = ram[rptr];          // first-word fall-through
   assign nempty    = fill != '0;
   assign half_full = fill >= CW'(DATA_DEPTH / 2);

   a_no_overflow: assert property (@(posedge aclk) disable iff (rst)
      !(we && fill == CW'(DATA_DEPTH)))
      else $error("fifo written while full");

   a_no_underflow: assert property (@(posedge aclk) disable iff (rst)
      !(re && !nempty))
      else $error("fifo read while empty");

endmodule

`default_nettype wire

// File: hw/mem_map_pkg.sv
// bank map: top word-address bit picks the bank, the rest is the offset
`default_nettype none

package mem_map_pkg;

   localparam int BANK_COUNT = 2;

   typedef logic [$clog2(BANK_COUNT)-1:0] bank_idx_t;

   // abits is the full word address width
   function automatic bank_idx_t bank_of(input logic [31:0] waddr, input int unsigned abits);
      return bank_idx_t'(waddr >> (abits - 1));
   endfunction

   // word offset inside the bank, upper bits cleared
   function automatic logic [31:0] offset_of(input logic [31:0] waddr, input int unsigned abits);
      return waddr & ((32'd1 << (abits - 1)) - 32'd1);
   endfunction

endpackage

`default_nettype wire

// File: hw/axi_pkg.sv
// AXI3 write channel types and field widths
// shared by the write slave and the top level
`default_nettype none

package axi_pkg;

   typedef enum logic [1:0] {
      FIXED    = 2'b00,   // same address every beat
      INCR     = 2'b01,   // word address steps by one
      WRAP     = 2'b10,   // steps inside an aligned window
      RESERVED = 2'b11    // beats consumed, nothing written
   } axi_burst_e;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,     // returned for reserved bursts
      DECERR = 2'b11
   } axi_resp_e;

   localparam int AXI_ADDR_W = 32;   // byte address
   localparam int AXI_ID_W   = 12;
   localparam int AXI_LEN_W  = 4;    // 1 to 16 beats
   localparam int AXI_DATA_W = 32;
   localparam int AXI_STRB_W = 4;    // one bit per byte lane

endpackage

`default_nettype wire
